//--- source/cpuTypesPkg.sv
// Word, register, immediate and shift types, ALU operations and data memory size.
package cpuTypesPkg;

  // ==========================================================================
  // Field widths
  // ==========================================================================

  localparam int WORD_W  = 32;
  localparam int REG_W   = 5;
  localparam int IMM_W   = 16;
  localparam int SHAMT_W = 5;
  localparam int AOP_W   = 4;

  // ==========================================================================
  // Data memory geometry
  // ==========================================================================

  // Depth in words.
  localparam int DMEM_WORDS  = 64;
  // Word index width without the byte offset.
  localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

  // ==========================================================================
  // Types
  // ==========================================================================

  // Data, address and instruction word.
  typedef logic [WORD_W-1:0]      word_t;

  // Register file index.
  typedef logic [REG_W-1:0]       regbits_t;

  // Instruction immediate field.
  typedef logic [IMM_W-1:0]       imm_t;

  // Shift amount field in instr[10:6].
  typedef logic [SHAMT_W-1:0]     shamt_t;

  // Word index into the data memory.
  typedef logic [DMEM_ADDR_W-1:0] dmemidx_t;

  // ALU operations. ALU_SLL doubles as the cleared value.
  typedef enum logic [AOP_W-1:0] {
    ALU_SLL  = 4'd0,
    ALU_SRL  = 4'd1,
    ALU_ADD  = 4'd2,
    ALU_SUB  = 4'd3,
    ALU_AND  = 4'd4,
    ALU_OR   = 4'd5,
    ALU_XOR  = 4'd6,
    ALU_NOR  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } aluop_t;

endpackage

//--- source/aluUnit.sv
// Combinational ALU with result and zero flag.
`timescale 1ns/1ps

module aluUnit (
  input  cpuTypesPkg::aluop_t aluOp,
  input  cpuTypesPkg::word_t  portA,
  input  cpuTypesPkg::word_t  portB,
  output cpuTypesPkg::word_t  result,
  output logic                zero
);
  import cpuTypesPkg::*;

  // Shift distance comes from the low bits of operand B.
  shamt_t shiftAmt;

  assign shiftAmt = portB[SHAMT_W-1:0];

  always_comb begin
    case (aluOp)
      ALU_SLL:  result = portA << shiftAmt;
      ALU_SRL:  result = portA >> shiftAmt;
      ALU_ADD:  result = portA + portB;
      ALU_SUB:  result = portA - portB;
      ALU_AND:  result = portA & portB;
      ALU_OR:   result = portA | portB;
      ALU_XOR:  result = portA ^ portB;
      ALU_NOR:  result = ~(portA | portB);
      // Signed then unsigned set on less than.
      ALU_SLT:  result = word_t'($signed(portA) < $signed(portB));
      ALU_SLTU: result = word_t'(portA < portB);
      default:  result = '0;
    endcase
  end

  // Branch compare uses SUB, so zero means equal operands.
  assign zero = (result == '0);

  // Only encoded operations may reach the ALU.
  aluOpDefined: assert final (
    $isunknown(aluOp) ||
    aluOp inside {ALU_SLL, ALU_SRL, ALU_ADD, ALU_SUB, ALU_AND,
                  ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU}
  ) else $error("aluUnit: undefined ALU operation %0h", aluOp);

endmodule

//--- source/executeStage.sv
// Execute stage with operand B select, ALU, result select and branch/jump redirect.
`timescale 1ns/1ps

module executeStage (
  input  cpuTypesPkg::aluop_t aluOp,
  input  logic                aluSrc,
  input  logic                lui,
  input  logic                zeroExt,
  input  logic                shiftSel,
  input  logic                branch,
  input  logic                bne,
  input  logic                jmp,
  input  logic                jmpReg,
  input  logic                jl,
  input  cpuTypesPkg::word_t  rdat1,
  input  cpuTypesPkg::word_t  rdat2,
  input  cpuTypesPkg::word_t  instr,
  input  cpuTypesPkg::word_t  incPC,
  output cpuTypesPkg::word_t  exResult,
  output logic                redirect,
  output cpuTypesPkg::word_t  redirectPC
);
  import cpuTypesPkg::*;

  imm_t   imm;
  shamt_t shamt;
  word_t  immExt;
  word_t  portB;
  word_t  aluResult;
  logic   aluZero;
  word_t  branchTarget;
  word_t  jumpTarget;
  logic   branchTaken;

  // ==========================================================================
  // Operand selection
  // ==========================================================================

  assign imm   = instr[IMM_W-1:0];
  assign shamt = instr[10:6];

  assign immExt = zeroExt ? word_t'(imm) : {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm};

  always_comb begin
    if (shiftSel) begin
      portB = word_t'(shamt);
    end else if (aluSrc) begin
      portB = immExt;
    end else begin
      portB = rdat2;
    end
  end

  aluUnit i_aluUnit (
    .aluOp  (aluOp),
    .portA  (rdat1),
    .portB  (portB),
    .result (aluResult),
    .zero   (aluZero)
  );

  // lui wins over link, link over the ALU.
  always_comb begin
    if (lui) begin
      exResult = {imm, {(WORD_W-IMM_W){1'b0}}};
    end else if (jl) begin
      exResult = incPC;
    end else begin
      exResult = aluResult;
    end
  end

  // ==========================================================================
  // Redirect resolution
  // ==========================================================================

  assign branchTarget = incPC + {{(WORD_W-IMM_W-2){imm[IMM_W-1]}}, imm, 2'b00};
  assign jumpTarget   = {incPC[31:28], instr[25:0], 2'b00};

  // beq takes on zero, bne on nonzero.
  assign branchTaken = branch && (aluZero != bne);
  assign redirect    = branchTaken || jmp || jmpReg;

  always_comb begin
    if (jmpReg) begin
      redirectPC = rdat1;
    end else if (jmp) begin
      redirectPC = jumpTarget;
    end else if (branchTaken) begin
      redirectPC = branchTarget;
    end else begin
      redirectPC = incPC;
    end
  end

  // Decode never issues both jump kinds at once.
  jumpKindsExclusive: assert final (!(jmp === 1'b1 && jmpReg === 1'b1))
    else $error("executeStage: jmp and jmpReg both high");

endmodule

//--- source/pipeRegExMem.sv
// EX/MEM pipeline register with enable stall and ihit-qualified flush.
`timescale 1ns/1ps

module pipeRegExMem (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  ihit,
  input  logic                  enable,
  input  logic                  flush,
  input  cpuTypesPkg::word_t    exResult,
  input  cpuTypesPkg::word_t    rdat2,
  input  cpuTypesPkg::regbits_t dest,
  input  logic                  memToReg,
  input  logic                  dREN,
  input  logic                  dWEN,
  input  logic                  WEN,
  output cpuTypesPkg::word_t    resultOut,
  output cpuTypesPkg::word_t    storeOut,
  output cpuTypesPkg::regbits_t destOut,
  output logic                  memToRegOut,
  output logic                  dRENOut,
  output logic                  dWENOut,
  output logic                  WENOut
);

  // Flush only counts once the fetch side has its instruction.
  logic flushHit;

  assign flushHit = flush && ihit;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      resultOut   <= '0;
      storeOut    <= '0;
      destOut     <= '0;
      memToRegOut <= 1'b0;
      dRENOut     <= 1'b0;
      dWENOut     <= 1'b0;
      WENOut      <= 1'b0;
    end else if (flushHit) begin
      // Turns the slot into a bubble.
      resultOut   <= '0;
      storeOut    <= '0;
      destOut     <= '0;
      memToRegOut <= 1'b0;
      dRENOut     <= 1'b0;
      dWENOut     <= 1'b0;
      WENOut      <= 1'b0;
    end else if (enable) begin
      resultOut   <= exResult;
      storeOut    <= rdat2;
      destOut     <= dest;
      memToRegOut <= memToReg;
      dRENOut     <= dREN;
      dWENOut     <= dWEN;
      WENOut      <= WEN;
    end
  end

  // A flushed slot must not write the register file or memory.
  flushKillsWrites: assert property (
    @(posedge CLK) disable iff (!nRST)
    flushHit |=> (!WENOut && !dWENOut)
  ) else $error("pipeRegExMem: write enable survived a flush");

endmodule

//--- source/memoryStage.sv
// Memory stage with word data memory, store and load, and write-back select.
`timescale 1ns/1ps

module memoryStage (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  enable,
  input  cpuTypesPkg::word_t    result,
  input  cpuTypesPkg::word_t    storeData,
  input  cpuTypesPkg::regbits_t dest,
  input  logic                  memToReg,
  input  logic                  dREN,
  input  logic                  dWEN,
  input  logic                  WEN,
  output cpuTypesPkg::word_t    wbData,
  output cpuTypesPkg::regbits_t wbDest,
  output logic                  wbEn
);
  import cpuTypesPkg::*;

  word_t    dmem [DMEM_WORDS];
  dmemidx_t wordIdx;
  word_t    loadData;

  // Word addressed; the two byte offset bits are dropped.
  assign wordIdx = result[DMEM_ADDR_W+1:2];

  // ==========================================================================
  // Data memory
  // ==========================================================================

  // Store lands at the edge closing its cycle and is held off during a stall.
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (dWEN && enable) begin
      dmem[wordIdx] <= storeData;
    end
  end

  // Asynchronous read.
  assign loadData = dREN ? dmem[wordIdx] : '0;

  // ==========================================================================
  // Write-back
  // ==========================================================================

  assign wbData = memToReg ? loadData : result;
  assign wbDest = dest;
  assign wbEn   = WEN;

  // One port, so a slot is either a load or a store.
  readWriteExclusive: assert property (
    @(posedge CLK) disable iff (!nRST)
    !(dREN && dWEN)
  ) else $error("memoryStage: dREN and dWEN both high");

endmodule

//--- source/exMemBackEnd.sv
// Back end top with execute stage, EX/MEM register and memory stage.
`timescale 1ns/1ps

module exMemBackEnd (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  ihit,
  input  logic                  enable,
  input  logic                  flush,
  input  cpuTypesPkg::aluop_t   aluOp,
  input  logic                  aluSrc,
  input  logic                  lui,
  input  logic                  zeroExt,
  input  logic                  shiftSel,
  input  logic                  branch,
  input  logic                  bne,
  input  logic                  jmp,
  input  logic                  jmpReg,
  input  logic                  jl,
  input  logic                  memToReg,
  input  logic                  dREN,
  input  logic                  dWEN,
  input  logic                  WEN,
  input  cpuTypesPkg::word_t    rdat1,
  input  cpuTypesPkg::word_t    rdat2,
  input  cpuTypesPkg::word_t    instr,
  input  cpuTypesPkg::word_t    pc,
  input  cpuTypesPkg::word_t    incPC,
  input  cpuTypesPkg::regbits_t dest,
  output cpuTypesPkg::word_t    wbData,
  output cpuTypesPkg::regbits_t wbDest,
  output logic                  wbEn,
  output logic                  redirect,
  output cpuTypesPkg::word_t    redirectPC
);
  import cpuTypesPkg::*;

  word_t    exResult;
  word_t    resultOut;
  word_t    storeOut;
  regbits_t destOut;
  logic     memToRegOut;
  logic     dRENOut;
  logic     dWENOut;
  logic     WENOut;

  executeStage i_executeStage (
    .aluOp      (aluOp),
    .aluSrc     (aluSrc),
    .lui        (lui),
    .zeroExt    (zeroExt),
    .shiftSel   (shiftSel),
    .branch     (branch),
    .bne        (bne),
    .jmp        (jmp),
    .jmpReg     (jmpReg),
    .jl         (jl),
    .rdat1      (rdat1),
    .rdat2      (rdat2),
    .instr      (instr),
    .incPC      (incPC),
    .exResult   (exResult),
    .redirect   (redirect),
    .redirectPC (redirectPC)
  );

  pipeRegExMem i_pipeRegExMem (
    .CLK         (CLK),
    .nRST        (nRST),
    .ihit        (ihit),
    .enable      (enable),
    .flush       (flush),
    .exResult    (exResult),
    .rdat2       (rdat2),
    .dest        (dest),
    .memToReg    (memToReg),
    .dREN        (dREN),
    .dWEN        (dWEN),
    .WEN         (WEN),
    .resultOut   (resultOut),
    .storeOut    (storeOut),
    .destOut     (destOut),
    .memToRegOut (memToRegOut),
    .dRENOut     (dRENOut),
    .dWENOut     (dWENOut),
    .WENOut      (WENOut)
  );

  memoryStage i_memoryStage (
    .CLK       (CLK),
    .nRST      (nRST),
    .enable    (enable),
    .result    (resultOut),
    .storeData (storeOut),
    .dest      (destOut),
    .memToReg  (memToRegOut),
    .dREN      (dRENOut),
    .dWEN      (dWENOut),
    .WEN       (WENOut),
    .wbData    (wbData),
    .wbDest    (wbDest),
    .wbEn      (wbEn)
  );

  // Link values and branch targets rely on incPC tracking pc.
  incPCTracksPC: assert property (
    @(posedge CLK) disable iff (!nRST)
    enable |-> (incPC == pc + 32'd4)
  ) else $error("exMemBackEnd: incPC is not pc + 4");

endmodule

//--- testbench/clockGen.sv
// Free-running testbench clock.
`timescale 1ns/1ps

module clockGen (
  output logic CLK
);

  // Period 8 ns and starts low.
  initial begin
    CLK = 1'b0;
    forever begin
      #4 CLK = ~CLK;
    end
  end

endmodule

//--- testbench/tbExMemBackEnd.sv
// EX/MEM back end testbench with stimulus, reference model, checks, watchdog and report.
`timescale 1ns/1ps

module tbExMemBackEnd;
  import cpuTypesPkg::*;

  // Upper bound on the cycles the tests take with reset included.
  localparam int TEST_CYCLES = 120;

  logic     CLK;
  logic     nRST;
  logic     ihit;
  logic     enable;
  logic     flush;
  aluop_t   aluOp;
  logic     aluSrc;
  logic     lui;
  logic     zeroExt;
  logic     shiftSel;
  logic     branch;
  logic     bne;
  logic     jmp;
  logic     jmpReg;
  logic     jl;
  logic     memToReg;
  logic     dREN;
  logic     dWEN;
  logic     WEN;
  word_t    rdat1;
  word_t    rdat2;
  word_t    instr;
  word_t    pc;
  word_t    incPC;
  regbits_t dest;
  word_t    wbData;
  regbits_t wbDest;
  logic     wbEn;
  logic     redirect;
  word_t    redirectPC;

  // Reference model state.
  word_t    modelMem [DMEM_WORDS];
  word_t    immW;
  word_t    opB;
  word_t    modelAlu;
  word_t    modelResult;
  logic     branchHit;
  logic     expRedir;
  word_t    expRedirPC;
  word_t    expData;
  regbits_t expDest;
  logic     expEn;
  logic     pendStore;
  dmemidx_t pendIdx;
  word_t    pendData;

  word_t    storeAddr [8];
  int       errors = 0;
  int       testCount = 0;

  clockGen i_clockGen (
    .CLK (CLK)
  );

  exMemBackEnd i_exMemBackEnd (.*);

  // ==========================================================================
  // Reference model
  // ==========================================================================

  function automatic word_t aluModel(aluop_t op, word_t a, word_t b);
    word_t r;
    case (op)
      ALU_SLL:  r = a << b[4:0];
      ALU_SRL:  r = a >> b[4:0];
      ALU_ADD:  r = a + b;
      ALU_SUB:  r = a - b;
      ALU_AND:  r = a & b;
      ALU_OR:   r = a | b;
      ALU_XOR:  r = a ^ b;
      ALU_NOR:  r = ~(a | b);
      ALU_SLT:  r = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: r = {31'b0, a < b};
      default:  r = 'x;
    endcase
    return r;
  endfunction

  always_comb begin
    immW = zeroExt ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
    opB = shiftSel ? {27'b0, instr[10:6]} : (aluSrc ? immW : rdat2);
    modelAlu = aluModel(aluOp, rdat1, opB);
    modelResult = lui ? {instr[15:0], 16'h0000} : (jl ? incPC : modelAlu);
    branchHit = branch && ((modelAlu == '0) != bne);
    expRedir = branchHit || jmp || jmpReg;
    if (jmpReg) begin
      expRedirPC = rdat1;
    end else if (jmp) begin
      expRedirPC = {incPC[31:28], instr[25:0], 2'b00};
    end else begin
      expRedirPC = incPC + {{14{instr[15]}}, instr[15:0], 2'b00};
    end
  end

  // Store of the held slot lands first, then the new slot reads the memory.
  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        modelMem[i] = '0;
      end
      expData   <= '0;
      expDest   <= '0;
      expEn     <= 1'b0;
      pendStore <= 1'b0;
    end else begin
      if (pendStore && enable) begin
        modelMem[pendIdx] = pendData;
      end
      if (flush && ihit) begin
        expData   <= '0;
        expDest   <= '0;
        expEn     <= 1'b0;
        pendStore <= 1'b0;
      end else if (enable) begin
        if (memToReg) begin
          expData <= dREN ? modelMem[modelResult[DMEM_ADDR_W+1:2]] : '0;
        end else begin
          expData <= modelResult;
        end
        expDest   <= dest;
        expEn     <= WEN;
        pendStore <= dWEN;
        pendIdx   <= modelResult[DMEM_ADDR_W+1:2];
        pendData  <= rdat2;
      end
    end
  end

  // ==========================================================================
  // Checks
  // ==========================================================================

  resetState: assert property (
    @(posedge CLK) !nRST |-> (!wbEn && wbData == '0)
  ) else begin
    errors++;
    $display("** Error @ %0t: during reset wbEn=%0b wbData=%h", $time,
             $sampled(wbEn), $sampled(wbData));
  end

  wbMatch: assert property (
    @(posedge CLK) disable iff (!nRST)
    wbEn == expEn && wbDest == expDest && wbData == expData
  ) else begin
    errors++;
    $display("** Error @ %0t: wb en=%0b dest=%0d data=%h, expected en=%0b dest=%0d data=%h",
             $time, $sampled(wbEn), $sampled(wbDest), $sampled(wbData),
             $sampled(expEn), $sampled(expDest), $sampled(expData));
  end

  redirectMatch: assert property (
    @(posedge CLK) redirect == expRedir && (!expRedir || redirectPC == expRedirPC)
  ) else begin
    errors++;
    $display("** Error @ %0t: redirect=%0b pc=%h, expected redirect=%0b pc=%h", $time,
             $sampled(redirect), $sampled(redirectPC), $sampled(expRedir),
             $sampled(expRedirPC));
  end

  // A stalled slot keeps its write-back outputs.
  stallHolds: assert property (
    @(posedge CLK) disable iff (!nRST)
    (!enable && !(flush && ihit)) |=> ($stable(wbData) && $stable(wbDest) && $stable(wbEn))
  ) else begin
    errors++;
    $display("** Error @ %0t: write-back changed during a stall", $time);
  end

  flushClears: assert property (
    @(posedge CLK) disable iff (!nRST)
    (flush && ihit) |=> (!wbEn && wbData == '0)
  ) else begin
    errors++;
    $display("** Error @ %0t: flushed slot still has wbEn=%0b wbData=%h", $time,
             $sampled(wbEn), $sampled(wbData));
  end

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  task automatic setIdle();
    ihit     = 1'b1;
    enable   = 1'b1;
    flush    = 1'b0;
    aluOp    = ALU_SLL;
    aluSrc   = 1'b0;
    lui      = 1'b0;
    zeroExt  = 1'b0;
    shiftSel = 1'b0;
    branch   = 1'b0;
    bne      = 1'b0;
    jmp      = 1'b0;
    jmpReg   = 1'b0;
    jl       = 1'b0;
    memToReg = 1'b0;
    dREN     = 1'b0;
    dWEN     = 1'b0;
    WEN      = 1'b0;
    rdat1    = $urandom;
    rdat2    = $urandom;
    instr    = $urandom;
    pc       = $urandom & 32'hFFFF_FFFC;
    incPC    = pc + 32'd4;
    dest     = regbits_t'($urandom);
  endtask

  // Inputs change 1 ns after the rising edge.
  task automatic nextCycle();
    @(posedge CLK);
    #1;
    setIdle();
  endtask

  // Word access at addr formed as rdat1 plus a zero offset.
  task automatic launchMem(input word_t addr, input logic isStore);
    aluOp  = ALU_ADD;
    aluSrc = 1'b1;
    rdat1  = addr;
    instr  = {instr[31:16], 16'h0000};
    if (isStore) begin
      dWEN = 1'b1;
    end else begin
      dREN     = 1'b1;
      memToReg = 1'b1;
      WEN      = 1'b1;
    end
  endtask

  // Lets the last launch of a test reach its check, then reports.
  task automatic finishTest(input string name, input int errBefore);
    repeat (2) nextCycle();
    testCount++;
    $display("%-12s finished with %0d errors", name, errors - errBefore);
  endtask

  initial begin
    int errBefore;
    void'($urandom(18));
    nRST = 1'b0;
    setIdle();
    repeat (16) @(posedge CLK);
    #1;
    nRST = 1'b1;
    finishTest("reset", 0);

    errBefore = errors;
    for (int op = 0; op < 10; op++) begin
      for (int form = 0; form < 4; form++) begin
        nextCycle();
        aluOp    = aluop_t'(op);
        WEN      = 1'b1;
        aluSrc   = (form == 1) || (form == 2);
        zeroExt  = (form == 2);
        shiftSel = (form == 3);
      end
    end
    nextCycle();
    lui = 1'b1;
    WEN = 1'b1;
    finishTest("aluOps", errBefore);

    // beq taken, beq not taken, bne taken, bne not taken, jumps.
    errBefore = errors;
    nextCycle();
    aluOp  = ALU_SUB;
    branch = 1'b1;
    rdat2  = rdat1;
    nextCycle();
    aluOp  = ALU_SUB;
    branch = 1'b1;
    nextCycle();
    aluOp  = ALU_SUB;
    branch = 1'b1;
    bne    = 1'b1;
    nextCycle();
    aluOp  = ALU_SUB;
    branch = 1'b1;
    bne    = 1'b1;
    rdat2  = rdat1;
    nextCycle();
    jmp = 1'b1;
    nextCycle();
    jmpReg = 1'b1;
    nextCycle();
    jmp  = 1'b1;
    jl   = 1'b1;
    WEN  = 1'b1;
    dest = 5'd31;
    finishTest("redirects", errBefore);

    // Loads run in reverse, so the last store is read back at once.
    errBefore = errors;
    for (int i = 0; i < 8; i++) begin
      nextCycle();
      storeAddr[i] = $urandom;
      launchMem(storeAddr[i], 1'b1);
    end
    for (int i = 7; i >= 0; i--) begin
      nextCycle();
      launchMem(storeAddr[i], 1'b0);
    end
    finishTest("storeLoad", errBefore);

    // Stores offered during a stall are never captured.
    errBefore = errors;
    nextCycle();
    aluOp = ALU_ADD;
    WEN   = 1'b1;
    repeat (4) begin
      nextCycle();
      enable = 1'b0;
      launchMem(storeAddr[0], 1'b1);
    end
    nextCycle();
    launchMem(storeAddr[0], 1'b0);
    finishTest("stall", errBefore);

    // A flushed ALU slot loses its register write, a flushed store its memory write.
    errBefore = errors;
    nextCycle();
    aluOp = ALU_OR;
    WEN   = 1'b1;
    flush = 1'b1;
    nextCycle();
    launchMem(storeAddr[1], 1'b1);
    flush = 1'b1;
    nextCycle();
    launchMem(storeAddr[1], 1'b0);
    // Without ihit the flush is ignored.
    nextCycle();
    aluOp = ALU_XOR;
    WEN   = 1'b1;
    flush = 1'b1;
    ihit  = 1'b0;
    finishTest("flush", errBefore);

    $display("Summary: %0d tests, %0d errors", testCount, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog.
  initial begin
    #((TEST_CYCLES + 100) * 8);
    $display("Timeout: the tests did not complete in the expected time");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- all.f
source/cpuTypesPkg.sv
source/aluUnit.sv
source/executeStage.sv
source/pipeRegExMem.sv
source/memoryStage.sv
source/exMemBackEnd.sv
testbench/clockGen.sv
testbench/tbExMemBackEnd.sv

//--- Bender.yml
package:
  name: ex_mem_back_end

sources:
  - source/cpuTypesPkg.sv
  - source/aluUnit.sv
  - source/executeStage.sv
  - source/pipeRegExMem.sv
  - source/memoryStage.sv
  - source/exMemBackEnd.sv
  - target: test
    files:
      - testbench/clockGen.sv
      - testbench/tbExMemBackEnd.sv
